// File: opl_pkg.sv
// shared definitions for the FM operator
// widths, vector types, register map and AXI4-Lite channel states

package opl_pkg;

    localparam int PHASE_ACC_WIDTH = 20;
    localparam int OP_OUT_WIDTH    = 13;
    localparam int ENV_WIDTH       = 9;
    localparam int REG_WS_WIDTH    = 3;

    typedef logic [PHASE_ACC_WIDTH-1:0]     phase_t;
    typedef logic [REG_WS_WIDTH-1:0]        ws_t;
    typedef logic [ENV_WIDTH-1:0]           env_t;    // 0 loudest, all ones muted
    typedef logic signed [OP_OUT_WIDTH-1:0] op_sample_t;
    typedef logic [7:0]                     axil_addr_t;
    typedef logic [31:0]                    axil_data_t;

    // register byte offsets
    localparam axil_addr_t REG_PHASE_INC = 8'h00;
    localparam axil_addr_t REG_WS        = 8'h04;
    localparam axil_addr_t REG_ENV       = 8'h08;
    localparam axil_addr_t REG_KEY_ON    = 8'h0C;    // write only
    localparam axil_addr_t REG_SAMPLE    = 8'h10;    // read only

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_t;

endpackage

// File: op_cfg_if.sv
// operator configuration from the control block to the phase generator
// includes the sample-rate enable and the key-on strobe
`timescale 1ns/1ps

interface op_cfg_if import opl_pkg::*; ();

    logic   sample_clk_en;    // one cycle every SAMPLE_DIV clocks
    phase_t phase_inc;
    ws_t    ws;
    env_t   env;
    logic   key_on_pulse;     // only ever high together with sample_clk_en

    modport ctrl (
        output sample_clk_en,
        output phase_inc,
        output ws,
        output env,
        output key_on_pulse
    );

    modport gen (
        input sample_clk_en,
        input phase_inc,
        input ws,
        input env,
        input key_on_pulse
    );

endinterface

// File: log_sine_lut.sv
// quarter-wave log-sine table, 256 entries
// holds -log2(sin) in 1/256 octave steps, computed at elaboration
`timescale 1ns/1ps

module log_sine_lut (
    input  logic       clk,
    input  logic [7:0] theta,
    output logic [11:0] out
);

    typedef logic [11:0] rom_t [256];

    function automatic rom_t build_rom();
        rom_t rom;
        real angle;
        real level;
        for (int i = 0; i < 256; i++) begin
            angle  = (real'(i) + 0.5) * 3.141592653589793 / 512.0;    // midpoint of step
            level  = -($ln($sin(angle)) / $ln(2.0)) * 256.0;
            rom[i] = 12'($rtoi(level + 0.5));
        end
        return rom;
    endfunction

    localparam rom_t ROM = build_rom();    // largest entry is about 2137

    always_ff @(posedge clk) begin
        out <= ROM[theta];
    end

endmodule

// File: exp_lut.sv
// exponential table, 256 entries
// fractional part of 2^(in/256) as a 10-bit mantissa, computed at elaboration
`timescale 1ns/1ps

module exp_lut (
    input  logic       clk,
    input  logic [7:0] in,
    output logic [9:0] out
);

    typedef logic [9:0] rom_t [256];

    function automatic rom_t build_rom();
        rom_t rom;
        real frac;
        for (int i = 0; i < 256; i++) begin
            frac   = $pow(2.0, real'(i) / 256.0) - 1.0;
            rom[i] = 10'($rtoi(frac * 1024.0 + 0.5));    // tops out at 1018
        end
        return rom;
    endfunction

    localparam rom_t ROM = build_rom();

    always_ff @(posedge clk) begin
        out <= ROM[in];
    end

endmodule

// File: phase_generator.sv
// operator phase generator: phase accumulator, log-sine lookup with gain,
// exponential conversion and shaping into one of eight waveforms
`timescale 1ns/1ps

module phase_generator import opl_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    op_cfg_if.gen      cfg,
    output op_sample_t out
);

    localparam op_sample_t OUT_MAX = {1'b0, {(OP_OUT_WIDTH-1){1'b1}}};
    localparam op_sample_t OUT_MIN = {1'b1, {(OP_OUT_WIDTH-1){1'b0}}};

    phase_t phase_acc;
    logic msb_q;
    logic msb_rise;
    logic is_odd_period;
    logic [7:0] theta;
    logic [11:0] log_sin_out;
    logic [7:0] ramp_frac;
    logic [11:0] log_ramp;
    logic [11:0] log_val;
    logic [12:0] log_sum;
    logic [9:0] exp_out;
    logic [4:0] gain_shift_q;
    logic [11:0] mantissa;
    logic [11:0] magnitude;
    logic full_scale_q;
    op_sample_t tmp_out1;
    op_sample_t tmp_ws2;
    op_sample_t tmp_ws4;

    // accumulator, moves once per sample tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            phase_acc <= '0;
        else if (cfg.sample_clk_en) begin
            if (cfg.key_on_pulse)
                phase_acc <= '0;
            else if (cfg.ws == 3'd4 || cfg.ws == 3'd5)
                phase_acc <= phase_acc + (cfg.phase_inc << 1);    // twice the rate
            else
                phase_acc <= phase_acc + cfg.phase_inc;
        end
    end

    // odd-period flag flips on each rising edge of the accumulator msb
    assign msb_rise = phase_acc[PHASE_ACC_WIDTH-1] && !msb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            msb_q         <= 1'b0;
            is_odd_period <= 1'b0;
        end else begin
            msb_q <= phase_acc[PHASE_ACC_WIDTH-1];
            if (cfg.sample_clk_en && cfg.key_on_pulse)
                is_odd_period <= 1'b0;    // parity counts from key-on
            else if (msb_rise)
                is_odd_period <= !is_odd_period;
        end
    end

    // mirror the second and fourth quadrant onto the quarter table
    assign theta = phase_acc[18] ? ~phase_acc[17:10] : phase_acc[17:10];

    log_sine_lut u_log_sine_lut (
        .clk   (clk),
        .theta (theta),
        .out   (log_sin_out)
    );

    // log sawtooth for ws 7, msb set mutes the middle two quadrants
    assign ramp_frac = phase_acc[19] ? ~phase_acc[17:10] : phase_acc[17:10];
    assign log_ramp  = {phase_acc[19] ^ phase_acc[18], ramp_frac, 3'b000};

    always_comb begin
        case (cfg.ws)
            3'd6:    log_val = '0;    // square sits at the table peak
            3'd7:    log_val = log_ramp;
            default: log_val = log_sin_out;
        endcase
    end

    assign log_sum = {1'b0, log_val} + {1'b0, cfg.env, 3'b000};    // env in 1/32 octave

    exp_lut u_exp_lut (
        .clk (clk),
        .in  (~log_sum[7:0]),
        .out (exp_out)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            gain_shift_q <= '0;
        else
            gain_shift_q <= log_sum[12:8];    // whole octaves, lines up with exp_out
    end

    // shift by whole octaves and apply the sign of the half period
    assign mantissa  = {1'b1, exp_out, 1'b0};
    assign magnitude = mantissa >> gain_shift_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tmp_out1     <= '0;
            full_scale_q <= 1'b0;
        end else begin
            full_scale_q <= (gain_shift_q == '0);
            if (phase_acc[19])
                tmp_out1 <= ~op_sample_t'({1'b0, magnitude});
            else
                tmp_out1 <= op_sample_t'({1'b0, magnitude});
        end
    end

    assign tmp_ws2 = (tmp_out1 < 0) ? ~tmp_out1 : tmp_out1;
    assign tmp_ws4 = is_odd_period ? tmp_out1 : '0;

    // waveform select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            out <= '0;
        else begin
            case (cfg.ws)
                3'd0: out <= tmp_out1;
                3'd1: out <= (tmp_out1 < 0) ? '0 : tmp_out1;
                3'd2: out <= tmp_ws2;
                3'd3: out <= phase_acc[18] ? '0 : tmp_ws2;
                3'd4: out <= tmp_ws4;
                3'd5: out <= (tmp_ws4 < 0) ? ~tmp_ws4 : tmp_ws4;
                3'd6: begin
                    if (full_scale_q)
                        out <= (tmp_out1 < 0) ? OUT_MIN : OUT_MAX;
                    else
                        out <= tmp_out1;    // attenuated square follows the gain
                end
                default: out <= tmp_out1;
            endcase
        end
    end

endmodule

// File: operator_ctrl.sv
// operator control block: AXI4-Lite register file, sample-rate divider,
// key-on request handling and capture of the output sample
`timescale 1ns/1ps

module operator_ctrl import opl_pkg::*; #(
    parameter int SAMPLE_DIV = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  axil_addr_t  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  axil_data_t  wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    input  axil_addr_t  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    output axil_data_t  rdata,
    output logic [1:0]  rresp,
    input  logic        rready,
    op_cfg_if.ctrl      cfg,
    input  op_sample_t  op_out,
    output op_sample_t  sample,
    output logic        sample_valid
);

    localparam int DIV_W = $clog2(SAMPLE_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);
    localparam int CAPTURE_DLY = 5;    // enable to op_out latency of the datapath

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic wr_accept;
    phase_t phase_inc_q;
    ws_t ws_q;
    env_t env_q;
    logic key_req;    // key-on waiting for the next sample tick
    logic [DIV_W-1:0] div_cnt;
    logic tick;
    logic sample_en_q;
    logic key_pulse_q;
    logic [CAPTURE_DLY-1:0] en_sr;

    assign wr_accept = (wr_state == WR_IDLE) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bvalid    = (wr_state == WR_RESP);
    assign arready   = (rd_state == RD_IDLE) && arvalid;
    assign rvalid    = (rd_state == RD_DATA);

    assign tick = (div_cnt == DIV_LAST);

    assign cfg.phase_inc     = phase_inc_q;
    assign cfg.ws            = ws_q;
    assign cfg.env           = env_q;
    assign cfg.sample_clk_en = sample_en_q;
    assign cfg.key_on_pulse  = key_pulse_q;

    // write channel and register file
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state    <= WR_IDLE;
            bresp       <= RESP_OKAY;
            phase_inc_q <= '0;
            ws_q        <= '0;
            env_q       <= '1;    // start muted
            key_req     <= 1'b0;
        end else begin
            if (key_req && tick)
                key_req <= 1'b0;    // request handed to the pulse below
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= WR_RESP;
                        bresp    <= RESP_OKAY;
                        case (awaddr)
                            REG_PHASE_INC: phase_inc_q <= wdata[PHASE_ACC_WIDTH-1:0];
                            REG_WS:        ws_q <= wdata[REG_WS_WIDTH-1:0];
                            REG_ENV:       env_q <= wdata[ENV_WIDTH-1:0];
                            REG_KEY_ON: begin
                                if (wdata[0])
                                    key_req <= 1'b1;    // a new request wins over the clear
                            end
                            default:       bresp <= RESP_SLVERR;
                        endcase
                    end
                end
                WR_RESP: begin
                    if (bready)
                        wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // read channel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= RD_IDLE;
            rdata    <= '0;
            rresp    <= RESP_OKAY;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arvalid) begin
                        rd_state <= RD_DATA;
                        rresp    <= RESP_OKAY;
                        case (araddr)
                            REG_PHASE_INC: rdata <= axil_data_t'(phase_inc_q);
                            REG_WS:        rdata <= axil_data_t'(ws_q);
                            REG_ENV:       rdata <= axil_data_t'(env_q);
                            REG_SAMPLE: begin
                                rdata <= {{(32-OP_OUT_WIDTH){sample[OP_OUT_WIDTH-1]}}, sample};
                            end
                            default: begin
                                rdata <= '0;
                                rresp <= RESP_SLVERR;
                            end
                        endcase
                    end
                end
                RD_DATA: begin
                    if (rready)
                        rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // sample-rate divider, key-on strobe and aligned capture of op_out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt      <= '0;
            sample_en_q  <= 1'b0;
            key_pulse_q  <= 1'b0;
            en_sr        <= '0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            div_cnt      <= tick ? '0 : div_cnt + 1'b1;
            sample_en_q  <= tick;
            key_pulse_q  <= tick && key_req;
            en_sr        <= {en_sr[CAPTURE_DLY-2:0], sample_en_q};
            sample_valid <= en_sr[CAPTURE_DLY-1];
            if (en_sr[CAPTURE_DLY-1])
                sample <= op_out;    // value derived from the phase of that tick
        end
    end

endmodule

// File: opl_operator_top.sv
// single FM operator: AXI4-Lite control block feeding the phase generator,
// with the captured sample and its strobe on plain ports
`timescale 1ns/1ps

module opl_operator_top import opl_pkg::*; #(
    parameter int SAMPLE_DIV = 16
) (
    input  logic        clk,
    input  logic        arst_n,
    input  axil_addr_t  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  axil_data_t  wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output logic [1:0]  bresp,
    input  logic        bready,
    input  axil_addr_t  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic        rvalid,
    output axil_data_t  rdata,
    output logic [1:0]  rresp,
    input  logic        rready,
    output op_sample_t  sample,
    output logic        sample_valid
);

    op_sample_t op_out;

    op_cfg_if cfg_if ();

    operator_ctrl #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_operator_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready),
        .cfg          (cfg_if.ctrl),
        .op_out       (op_out),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    phase_generator u_phase_generator (
        .clk    (clk),
        .arst_n (arst_n),
        .cfg    (cfg_if.gen),
        .out    (op_out)
    );

endmodule

// File: opl_checker.sv
// output checker for the FM operator
// compares bus responses and captured samples with the expected rules
`timescale 1ns/1ps

module opl_checker import opl_pkg::*; (
    input  logic       clk,
    input  logic       bvalid,
    input  logic       bready,
    input  logic [1:0] bresp,
    input  logic       rvalid,
    input  logic       rready,
    input  logic [1:0] rresp,
    input  axil_data_t rdata,
    input  op_sample_t sample,
    input  logic       sample_valid,
    input  logic [1:0] exp_resp,
    input  axil_data_t exp_rdata,
    input  logic       chk_rdata,
    input  int         mode,
    input  phase_t     phase_inc,
    input  int         obs_count,
    input  logic       arm,
    output logic       done,
    output int         bus_errors,
    output int         sample_errors
);

    localparam int CHK_MUTE   = 1;
    localparam int CHK_NONNEG = 2;
    localparam int CHK_SQUARE = 3;
    localparam int CHK_KEYON  = 4;
    localparam int CHK_SYMM   = 5;
    localparam int CHK_ALT    = 6;

    op_sample_t hist [$];    // samples of the current observation window
    int seen;
    bit skip;                // first strobe may come from a tick before the change

    initial begin
        bus_errors    = 0;
        sample_errors = 0;
        done          = 1'b0;
    end

    task automatic flag(input string expected, input op_sample_t actual);
        $display("[ERROR] %0t ns sample expected %s actual %0d", $time, expected, actual);
        sample_errors++;
    endtask

    // alternating wave is silent until the doubled-step msb first rises
    function automatic bit zero_at(input longint n, input longint p);
        return (((n * 2 * p + (64'd1 << 19)) >> 20) % 2) == 0;
    endfunction

    task automatic check_sample(input op_sample_t s, input int n);
        int half;
        op_sample_t ref_s;
        case (mode)
            CHK_MUTE:   if (s > 1 || s < -1) flag("magnitude <= 1", s);
            CHK_NONNEG: if (s < 0) flag(">= 0", s);
            CHK_SQUARE: if (s != 4095 && s != -4096) flag("4095 or -4096", s);
            CHK_KEYON: begin
                if (n == 0 && (s > 16 || s < -16))
                    flag("within 16 of 0", s);
                else if (s < 0)
                    flag(">= 0", s);
            end
            CHK_SYMM: begin
                half = (1 << 19) / int'(phase_inc);    // half period in samples
                if (n >= half) begin
                    ref_s = ~hist[n-half];
                    if (int'(s) - int'(ref_s) > 1 || int'(ref_s) - int'(s) > 1)
                        flag($sformatf("%0d", ref_s), s);
                end
            end
            CHK_ALT: begin
                if (zero_at(n, phase_inc) && zero_at(n + 1, phase_inc) && s != 0)
                    flag("0", s);
            end
            default: ;
        endcase
    endtask

    // bus responses
    always @(posedge clk) begin
        if (bvalid && bready && bresp !== exp_resp) begin
            $display("[ERROR] %0t ns bresp expected %0d actual %0d", $time, exp_resp, bresp);
            bus_errors++;
        end
        if (rvalid && rready) begin
            if (rresp !== exp_resp) begin
                $display("[ERROR] %0t ns rresp expected %0d actual %0d",
                         $time, exp_resp, rresp);
                bus_errors++;
            end
            if (chk_rdata && rdata !== exp_rdata) begin
                $display("[ERROR] %0t ns rdata expected 0x%08h actual 0x%08h",
                         $time, exp_rdata, rdata);
                bus_errors++;
            end
        end
    end

    // sample strobes inside an armed window
    always @(posedge clk) begin
        if (!arm) begin
            seen = 0;
            skip = 1'b1;
            done <= 1'b0;
            hist.delete();
        end else if (sample_valid && !done) begin
            if (skip)
                skip = 1'b0;
            else begin
                check_sample(sample, seen);
                hist.push_back(sample);
                seen++;
                if (seen >= obs_count)
                    done <= 1'b1;
            end
        end
    end

endmodule

// File: opl_sva.sv
// bus handshake and sample strobe assertions for the FM operator top
`timescale 1ns/1ps

module opl_sva (
    input logic       clk,
    input logic       arst_n,
    input logic       awvalid,
    input logic       awready,
    input logic       wvalid,
    input logic       wready,
    input logic       bvalid,
    input logic       bready,
    input logic [1:0] bresp,
    input logic       arvalid,
    input logic       arready,
    input logic       rvalid,
    input logic       rready,
    input logic [31:0] rdata,
    input logic [1:0] rresp,
    input logic       sample_valid
);

    int sva_errors;    // failed assertion count

    initial sva_errors = 0;

    a_aw_accept: assert property (@(posedge clk) disable iff (!arst_n)
        awready |-> awvalid && wvalid && wready)
        else begin
            $error("write accepted without both valids");
            sva_errors++;
        end

    a_b_follows: assert property (@(posedge clk) disable iff (!arst_n)
        awready |=> bvalid)
        else begin
            $error("bvalid missing after write accept");
            sva_errors++;
        end

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("write response dropped");
            sva_errors++;
        end

    a_r_follows: assert property (@(posedge clk) disable iff (!arst_n)
        arready |=> rvalid)
        else begin
            $error("rvalid missing after read accept");
            sva_errors++;
        end

    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("read response dropped or changed");
            sva_errors++;
        end

    a_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid)
        else begin
            $error("sample_valid longer than one cycle");
            sva_errors++;
        end

endmodule

bind opl_operator_top opl_sva u_opl_sva (.*);

// File: tb_opl_operator.sv
// testbench for the FM operator: register table, sample windows and watchdog
`timescale 1ns/1ps

module tb_opl_operator import opl_pkg::*; ();

    localparam int SAMPLE_DIV = 16;
    localparam int CLK_PERIOD = 40;
    localparam int CHK_NONE   = 0;
    localparam int CHK_MUTE   = 1;
    localparam int CHK_NONNEG = 2;
    localparam int CHK_SQUARE = 3;
    localparam int CHK_KEYON  = 4;
    localparam int CHK_SYMM   = 5;
    localparam int CHK_ALT    = 6;

    typedef struct {
        bit         is_read;
        axil_addr_t addr;
        axil_data_t data;
        logic [1:0] resp;
        axil_data_t rdata;
        bit         chk_rdata;
        int         nsamp;
        int         mode;
    } row_t;

    row_t table_q [$];

    logic clk;
    logic arst_n;
    axil_addr_t awaddr;
    logic awvalid;
    logic awready;
    axil_data_t wdata;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic bready;
    axil_addr_t araddr;
    logic arvalid;
    logic arready;
    logic rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic rready;
    op_sample_t sample;
    logic sample_valid;
    logic [1:0] exp_resp;
    axil_data_t exp_rdata;
    logic chk_rdata;
    int mode;
    phase_t cur_phase_inc;
    int obs_count;
    logic arm;
    logic done;
    int bus_errors;
    int sample_errors;
    int assert_errors;

    opl_operator_top #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_opl_operator_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bresp        (bresp),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rdata        (rdata),
        .rresp        (rresp),
        .rready       (rready),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    opl_checker u_opl_checker (
        .clk           (clk),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .rresp         (rresp),
        .rdata         (rdata),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .exp_resp      (exp_resp),
        .exp_rdata     (exp_rdata),
        .chk_rdata     (chk_rdata),
        .mode          (mode),
        .phase_inc     (cur_phase_inc),
        .obs_count     (obs_count),
        .arm           (arm),
        .done          (done),
        .bus_errors    (bus_errors),
        .sample_errors (sample_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic add_row(input bit is_read, input axil_addr_t addr, input axil_data_t data,
                           input logic [1:0] resp, input axil_data_t rd, input bit chk,
                           input int nsamp, input int chk_mode);
        row_t r;
        r.is_read   = is_read;
        r.addr      = addr;
        r.data      = data;
        r.resp      = resp;
        r.rdata     = rd;
        r.chk_rdata = chk;
        r.nsamp     = nsamp;
        r.mode      = chk_mode;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        axil_data_t inc;
        // readback and error responses
        add_row(1, REG_PHASE_INC, 0, RESP_OKAY, 32'h0, 1, 0, CHK_NONE);
        add_row(1, REG_ENV, 0, RESP_OKAY, 32'h1FF, 1, 0, CHK_NONE);
        add_row(0, REG_PHASE_INC, 32'hABCDE123, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(1, REG_PHASE_INC, 0, RESP_OKAY, 32'h000DE123, 1, 0, CHK_NONE);
        add_row(0, REG_WS, 32'hFFFFFFFD, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(1, REG_WS, 0, RESP_OKAY, 32'h5, 1, 0, CHK_NONE);
        add_row(0, REG_ENV, 32'h3F0, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(1, REG_ENV, 0, RESP_OKAY, 32'h1F0, 1, 0, CHK_NONE);
        add_row(0, 8'h14, 32'h1, RESP_SLVERR, 0, 0, 0, CHK_NONE);
        add_row(0, 8'h02, 32'h1, RESP_SLVERR, 0, 0, 0, CHK_NONE);
        add_row(1, 8'h20, 0, RESP_SLVERR, 32'h0, 1, 0, CHK_NONE);
        add_row(1, REG_KEY_ON, 0, RESP_SLVERR, 32'h0, 1, 0, CHK_NONE);
        add_row(1, REG_SAMPLE, 0, RESP_OKAY, 0, 0, 0, CHK_NONE);
        // muted output for several waveforms
        add_row(0, REG_ENV, 32'h1FF, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_PHASE_INC, 32'h2345, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_WS, 32'h0, RESP_OKAY, 0, 0, 20, CHK_MUTE);
        add_row(0, REG_WS, 32'h3, RESP_OKAY, 0, 0, 20, CHK_MUTE);
        add_row(0, REG_WS, 32'h5, RESP_OKAY, 0, 0, 20, CHK_MUTE);
        add_row(0, REG_WS, 32'h6, RESP_OKAY, 0, 0, 20, CHK_MUTE);
        add_row(0, REG_WS, 32'h7, RESP_OKAY, 0, 0, 20, CHK_MUTE);
        // sign rules at full level
        add_row(0, REG_ENV, 32'h0, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_WS, 32'h1, RESP_OKAY, 0, 0, 40, CHK_NONNEG);
        add_row(0, REG_WS, 32'h2, RESP_OKAY, 0, 0, 40, CHK_NONNEG);
        add_row(0, REG_WS, 32'h6, RESP_OKAY, 0, 0, 40, CHK_SQUARE);
        add_row(0, REG_WS, 32'h5, RESP_OKAY, 0, 0, 40, CHK_NONNEG);
        // key-on phase reset
        add_row(0, REG_WS, 32'h0, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_PHASE_INC, 32'h40, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_KEY_ON, 32'h1, RESP_OKAY, 0, 0, 40, CHK_KEYON);
        // half-period symmetry, power of two steps
        repeat (2) begin
            inc = 32'h1 << (13 + ($urandom % 4));
            add_row(0, REG_PHASE_INC, inc, RESP_OKAY, 0, 0, 140, CHK_SYMM);
        end
        // alternating waveform
        add_row(0, REG_WS, 32'h4, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_PHASE_INC, 32'h4000, RESP_OKAY, 0, 0, 0, CHK_NONE);
        add_row(0, REG_KEY_ON, 32'h1, RESP_OKAY, 0, 0, 80, CHK_ALT);
    endtask

    task automatic bus_write(input axil_addr_t addr, input axil_data_t data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge clk); while (!awready);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk); while (!bvalid);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input axil_addr_t addr);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        exp_resp  = r.resp;
        exp_rdata = r.rdata;
        chk_rdata = r.chk_rdata;
        if (r.is_read)
            bus_read(r.addr);
        else begin
            bus_write(r.addr, r.data);
            if (r.resp == RESP_OKAY && r.addr == REG_PHASE_INC)
                cur_phase_inc = r.data[PHASE_ACC_WIDTH-1:0];
        end
        if (r.nsamp > 0) begin
            mode      = r.mode;
            obs_count = r.nsamp;
            @(negedge clk);
            arm = 1'b1;
            do @(posedge clk); while (!done);
            @(negedge clk);
            arm = 1'b0;
        end
    endtask

    initial begin
        arst_n        = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        exp_resp      = RESP_OKAY;
        exp_rdata     = '0;
        chk_rdata     = 1'b0;
        mode          = CHK_NONE;
        cur_phase_inc = '0;
        obs_count     = 0;
        arm           = 1'b0;
        void'($urandom(3));
        build_table();
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        foreach (table_q[i])
            apply_row(table_q[i]);
        repeat (2) @(negedge clk);
        assert_errors = u_opl_operator_top.u_opl_sva.sva_errors;
        $display("errors: bus %0d, sample %0d, assertion %0d",
                 bus_errors, sample_errors, assert_errors);
        if (bus_errors == 0 && sample_errors == 0 && assert_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // watchdog sized from the sample windows plus half again
    initial begin
        longint budget;
        int total;
        #1;
        total = 0;
        foreach (table_q[i])
            total += table_q[i].nsamp + 1;
        budget = longint'(total) * SAMPLE_DIV * CLK_PERIOD * 3 / 2;
        #(budget + 8 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d ns", budget);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: compile.f
opl_pkg.sv
op_cfg_if.sv
log_sine_lut.sv
exp_lut.sv
phase_generator.sv
operator_ctrl.sv
opl_operator_top.sv
opl_checker.sv
opl_sva.sv
tb_opl_operator.sv
